//--- source/gpu_settings.svh
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// Warps sharing the front end
`define GPU_NUM_WARPS 4

// Threads per warp, one mask bit each
`define GPU_NUM_THREADS 4

// Named barriers available to the warps
`define GPU_NUM_BARRIERS 2

// Entries in each warp's IPDOM stack
`define GPU_IPDOM_DEPTH 4

// Where warp 0 starts after reset
`define GPU_START_PC 32'h8000_0000

`endif

//--- source/warp_pkg.sv
`include "gpu_settings.svh"

package warp_pkg;

	// Index of one warp
	typedef logic [$clog2(`GPU_NUM_WARPS)-1:0] warp_id_t;

	// One bit per thread of a warp
	typedef logic [`GPU_NUM_THREADS-1:0] tmask_t;

	// Program counter
	typedef logic [31:0] pc_t;

	// Number of warps, wide enough to hold the full count
	typedef logic [$clog2(`GPU_NUM_WARPS):0] wcount_t;

	// Saved state for reconvergence
	// A fallthrough entry only restores the mask, the PC keeps running
	typedef struct packed {
		logic fallthrough;
		pc_t pc;
		tmask_t tmask;
	} ipdom_entry_t;

endpackage

//--- source/cf_pkg.sv
`include "gpu_settings.svh"

package cf_pkg;

	// Control-flow events reported back by the execute stage
	typedef enum logic [3:0] {
		CF_ADVANCE = 4'd0,
		CF_JAL     = 4'd1,
		CF_BRANCH  = 4'd2,
		CF_SPLIT   = 4'd3,
		CF_JOIN    = 4'd4,
		CF_TMC     = 4'd5,
		CF_BAR     = 4'd6,
		CF_HALT    = 4'd7,
		CF_WSPAWN  = 4'd8
	} cf_op_t;

	// Names one barrier of the barrier table
	typedef logic [$clog2(`GPU_NUM_BARRIERS)-1:0] bar_id_t;

endpackage

//--- source/ipdom_stack.sv
`timescale 1ns/10ps

module ipdom_stack #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input entry_t push_lo,
	input entry_t push_hi,
	output entry_t top,
	output logic empty
);

	localparam int AW = $clog2(DEPTH);
	localparam int PW = $clog2(DEPTH + 1);

	entry_t mem [DEPTH];

	// Number of valid entries, top lives at sp - 1
	logic [PW-1:0] sp;
	logic [PW-1:0] sp_inc;
	logic [PW-1:0] sp_dec;

	assign sp_inc = sp + PW'(1);
	assign sp_dec = sp - PW'(1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sp <= '0;
		end else if (push) begin
			sp <= sp + PW'(2);
		end else if (pop) begin
			sp <= sp_dec;
		end
	end

	// Lower entry goes in first so the upper one is popped first
	always_ff @(posedge clk) begin
		if (push) begin
			mem[sp[AW-1:0]] <= push_lo;
			mem[sp_inc[AW-1:0]] <= push_hi;
		end
	end

	assign top = mem[sp_dec[AW-1:0]];
	assign empty = (sp == '0);

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> (sp <= PW'(DEPTH - 2)));

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

endmodule

//--- source/barrier_table.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module barrier_table (
	input logic clk,
	input logic reset,
	input logic bar_arrive,
	input cf_pkg::bar_id_t bar_id,
	input warp_pkg::warp_id_t bar_warp,
	input warp_pkg::wcount_t bar_count,
	output logic [`GPU_NUM_WARPS-1:0] bar_hold_mask
);

	localparam int NW = `GPU_NUM_WARPS;
	localparam int NB = `GPU_NUM_BARRIERS;

	// Warps waiting at each barrier
	logic [NW-1:0] arrived [NB];

	warp_pkg::wcount_t cur_count;
	logic reach;

	assign cur_count = warp_pkg::wcount_t'($countones(arrived[bar_id]));

	// This arrival is the last one the barrier waits for
	assign reach = (cur_count + warp_pkg::wcount_t'(1)) == bar_count;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int b = 0; b < NB; b++) begin
				arrived[b] <= '0;
			end
		end else if (bar_arrive) begin
			if (reach) begin
				arrived[bar_id] <= '0;
			end else begin
				arrived[bar_id][bar_warp] <= 1'b1;
			end
		end
	end

	// A warp is held while it waits at any barrier
	always_comb begin
		bar_hold_mask = '0;
		for (int b = 0; b < NB; b++) begin
			bar_hold_mask = bar_hold_mask | arrived[b];
		end
	end

	// A held warp cannot have been issued, so it cannot arrive again
	a_arrive_not_held: assert property (@(posedge clk) disable iff (reset)
		bar_arrive |-> !bar_hold_mask[bar_warp]);

	a_count_nonzero: assert property (@(posedge clk) disable iff (reset)
		bar_arrive |-> (bar_count != '0));

endmodule

//--- source/warp_scheduler.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module warp_scheduler (
	input logic clk,
	input logic reset,
	input logic cf_valid,
	input cf_pkg::cf_op_t cf_op,
	input warp_pkg::warp_id_t cf_warp,
	input warp_pkg::pc_t cf_pc,
	input logic cf_taken,
	input warp_pkg::tmask_t cf_mask,
	input warp_pkg::tmask_t cf_later_mask,
	input cf_pkg::bar_id_t cf_bar_id,
	input warp_pkg::wcount_t cf_bar_count,
	input logic [`GPU_NUM_WARPS-1:0] bar_hold_mask,
	output logic bar_arrive,
	output cf_pkg::bar_id_t bar_id,
	output warp_pkg::warp_id_t bar_warp,
	output warp_pkg::wcount_t bar_count,
	output logic issue_valid,
	input logic issue_ready,
	output warp_pkg::warp_id_t issue_warp,
	output warp_pkg::pc_t issue_pc,
	output warp_pkg::tmask_t issue_mask,
	output logic ebreak
);

	localparam int NW = `GPU_NUM_WARPS;

	// Per-warp state
	warp_pkg::pc_t pc_q [NW];
	warp_pkg::tmask_t mask_q [NW];
	logic [NW-1:0] active;
	logic [NW-1:0] stalled;
	logic [NW-1:0] served;

	// Round-robin pick
	logic [NW-1:0] eligible;
	logic [NW-1:0] fresh;
	logic [NW-1:0] cand;
	logic [NW-1:0] pick_onehot;
	logic new_round;
	logic pick_found;
	logic load;
	warp_pkg::warp_id_t pick_warp;

	// IPDOM stacks
	logic [NW-1:0] stack_push;
	logic [NW-1:0] stack_pop;
	logic [NW-1:0] stack_empty;
	warp_pkg::ipdom_entry_t stack_top [NW];
	warp_pkg::ipdom_entry_t split_lo;
	warp_pkg::ipdom_entry_t split_hi;
	warp_pkg::ipdom_entry_t join_entry;
	logic join_ok;

	always_comb begin
		eligible = active & ~stalled & ~bar_hold_mask;
		fresh = eligible & ~served;
		// Everyone ready has had a turn, start over
		new_round = (fresh == '0);
		cand = new_round ? eligible : fresh;
		pick_found = |cand;
		pick_warp = '0;
		for (int w = NW - 1; w >= 0; w--) begin
			if (cand[w]) begin
				pick_warp = warp_pkg::warp_id_t'(w);
			end
		end
		pick_onehot = '0;
		pick_onehot[pick_warp] = pick_found;
	end

	// Issue register may take a new warp when empty or draining
	assign load = pick_found && (!issue_valid || issue_ready);

	// Split pushes the reconvergence mask below the deferred path
	always_comb begin
		split_lo.fallthrough = 1'b1;
		split_lo.pc = '0;
		split_lo.tmask = mask_q[cf_warp];
		split_hi.fallthrough = 1'b0;
		split_hi.pc = cf_pc;
		split_hi.tmask = cf_later_mask;
	end

	for (genvar w = 0; w < NW; w++) begin : g_stack
		assign stack_push[w] = cf_valid && (cf_op == cf_pkg::CF_SPLIT) &&
			(cf_warp == warp_pkg::warp_id_t'(w));
		assign stack_pop[w] = cf_valid && (cf_op == cf_pkg::CF_JOIN) &&
			(cf_warp == warp_pkg::warp_id_t'(w));

		ipdom_stack #(
			.entry_t(warp_pkg::ipdom_entry_t),
			.DEPTH(`GPU_IPDOM_DEPTH)
		) stack0 (
			.clk(clk),
			.reset(reset),
			.push(stack_push[w]),
			.pop(stack_pop[w]),
			.push_lo(split_lo),
			.push_hi(split_hi),
			.top(stack_top[w]),
			.empty(stack_empty[w])
		);
	end

	assign join_entry = stack_top[cf_warp];
	assign join_ok = !stack_empty[cf_warp];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int w = 0; w < NW; w++) begin
				pc_q[w] <= '0;
				mask_q[w] <= warp_pkg::tmask_t'(1);
			end
			pc_q[0] <= `GPU_START_PC;
			active <= NW'(1);
			stalled <= '0;
			served <= '0;
		end else begin
			// Issued warp waits for its event, PC moves on
			if (load) begin
				stalled[pick_warp] <= 1'b1;
				pc_q[pick_warp] <= pc_q[pick_warp] + 32'd4;
				served <= (new_round ? '0 : served) | pick_onehot;
			end
			if (cf_valid) begin
				stalled[cf_warp] <= 1'b0;
				case (cf_op)
					cf_pkg::CF_JAL: pc_q[cf_warp] <= cf_pc;
					cf_pkg::CF_BRANCH: begin
						if (cf_taken) begin
							pc_q[cf_warp] <= cf_pc;
						end
					end
					cf_pkg::CF_SPLIT: mask_q[cf_warp] <= cf_mask;
					cf_pkg::CF_JOIN: begin
						if (join_ok) begin
							mask_q[cf_warp] <= join_entry.tmask;
							if (!join_entry.fallthrough) begin
								pc_q[cf_warp] <= join_entry.pc;
							end
						end
					end
					cf_pkg::CF_TMC: begin
						mask_q[cf_warp] <= cf_mask;
						if (cf_mask == '0) begin
							active[cf_warp] <= 1'b0;
						end
					end
					cf_pkg::CF_HALT: active[cf_warp] <= 1'b0;
					cf_pkg::CF_WSPAWN: begin
						// Warp 0 is never respawned
						for (int w = 1; w < NW; w++) begin
							if (cf_mask[w]) begin
								active[w] <= 1'b1;
								stalled[w] <= 1'b0;
								pc_q[w] <= cf_pc;
								mask_q[w] <= warp_pkg::tmask_t'(1);
							end
						end
					end
					// Advance and barrier only release the warp
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else if (load) begin
			issue_valid <= 1'b1;
		end else if (issue_ready) begin
			issue_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			issue_warp <= pick_warp;
			issue_pc <= pc_q[pick_warp];
			issue_mask <= mask_q[pick_warp];
		end
	end

	assign bar_arrive = cf_valid && (cf_op == cf_pkg::CF_BAR);
	assign bar_id = cf_bar_id;
	assign bar_warp = cf_warp;
	assign bar_count = cf_bar_count;

	assign ebreak = (active == '0);

	a_event_active: assert property (@(posedge clk) disable iff (reset)
		(cf_valid && cf_op != cf_pkg::CF_WSPAWN) |-> active[cf_warp]);

	// Events answer an earlier issue of the same warp
	a_event_stalled: assert property (@(posedge clk) disable iff (reset)
		(cf_valid && !(cf_op inside {cf_pkg::CF_WSPAWN, cf_pkg::CF_BAR}))
		|-> stalled[cf_warp]);

endmodule

//--- source/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input warp_pkg::warp_id_t issue_warp,
	input warp_pkg::pc_t issue_pc,
	input warp_pkg::tmask_t issue_mask,
	output logic issue_ready,
	output logic arvalid,
	output logic [31:0] araddr,
	output logic [2:0] arprot,
	input logic arready,
	input logic rvalid,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	output logic rready,
	output logic out_valid,
	input logic out_ready,
	output warp_pkg::warp_id_t out_warp,
	output warp_pkg::pc_t out_pc,
	output warp_pkg::tmask_t out_mask,
	output logic [31:0] out_instr
);

	// Read slot, busy from issue until the R beat
	logic rd_busy;
	warp_pkg::warp_id_t rd_warp;
	warp_pkg::pc_t rd_pc;
	warp_pkg::tmask_t rd_mask;

	logic issue_fire;
	logic r_fire;

	// R is taken only when the output buffer has room
	assign rready = !out_valid || out_ready;
	assign r_fire = rvalid && rready;

	assign issue_ready = !rd_busy || r_fire;
	assign issue_fire = issue_valid && issue_ready;

	assign araddr = rd_pc;
	assign arprot = 3'b000;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_busy <= 1'b0;
			arvalid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (r_fire) begin
				rd_busy <= 1'b0;
			end
			if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (issue_fire) begin
				rd_busy <= 1'b1;
				arvalid <= 1'b1;
			end
			if (r_fire) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue_fire) begin
			rd_warp <= issue_warp;
			rd_pc <= issue_pc;
			rd_mask <= issue_mask;
		end
		if (r_fire) begin
			out_warp <= rd_warp;
			out_pc <= rd_pc;
			out_mask <= rd_mask;
			// Error responses turn into a zero word
			out_instr <= (rresp == 2'b00) ? rdata : '0;
		end
	end

	// R only after the address went out
	a_r_expected: assert property (@(posedge clk) disable iff (reset)
		rvalid |-> (rd_busy && !arvalid));

	a_ar_stable: assert property (@(posedge clk) disable iff (reset)
		(arvalid && !arready) |=> (arvalid && $stable(araddr)));

endmodule

//--- source/warp_frontend_top.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module warp_frontend_top (
	input logic clk,
	input logic reset,
	input logic cf_valid,
	input cf_pkg::cf_op_t cf_op,
	input warp_pkg::warp_id_t cf_warp,
	input warp_pkg::pc_t cf_pc,
	input logic cf_taken,
	input warp_pkg::tmask_t cf_mask,
	input warp_pkg::tmask_t cf_later_mask,
	input cf_pkg::bar_id_t cf_bar_id,
	input warp_pkg::wcount_t cf_bar_count,
	output logic arvalid,
	output logic [31:0] araddr,
	output logic [2:0] arprot,
	input logic arready,
	input logic rvalid,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	output logic rready,
	output logic out_valid,
	input logic out_ready,
	output warp_pkg::warp_id_t out_warp,
	output warp_pkg::pc_t out_pc,
	output warp_pkg::tmask_t out_mask,
	output logic [31:0] out_instr,
	output logic ebreak
);

	logic bar_arrive;
	cf_pkg::bar_id_t bar_id;
	warp_pkg::warp_id_t bar_warp;
	warp_pkg::wcount_t bar_count;
	logic [`GPU_NUM_WARPS-1:0] bar_hold_mask;

	logic issue_valid;
	logic issue_ready;
	warp_pkg::warp_id_t issue_warp;
	warp_pkg::pc_t issue_pc;
	warp_pkg::tmask_t issue_mask;

	warp_scheduler sched0 (
		.clk(clk),
		.reset(reset),
		.cf_valid(cf_valid),
		.cf_op(cf_op),
		.cf_warp(cf_warp),
		.cf_pc(cf_pc),
		.cf_taken(cf_taken),
		.cf_mask(cf_mask),
		.cf_later_mask(cf_later_mask),
		.cf_bar_id(cf_bar_id),
		.cf_bar_count(cf_bar_count),
		.bar_hold_mask(bar_hold_mask),
		.bar_arrive(bar_arrive),
		.bar_id(bar_id),
		.bar_warp(bar_warp),
		.bar_count(bar_count),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_warp(issue_warp),
		.issue_pc(issue_pc),
		.issue_mask(issue_mask),
		.ebreak(ebreak)
	);

	barrier_table bar0 (
		.clk(clk),
		.reset(reset),
		.bar_arrive(bar_arrive),
		.bar_id(bar_id),
		.bar_warp(bar_warp),
		.bar_count(bar_count),
		.bar_hold_mask(bar_hold_mask)
	);

	fetch_stage fetch0 (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_warp(issue_warp),
		.issue_pc(issue_pc),
		.issue_mask(issue_mask),
		.issue_ready(issue_ready),
		.arvalid(arvalid),
		.araddr(araddr),
		.arprot(arprot),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_warp(out_warp),
		.out_pc(out_pc),
		.out_mask(out_mask),
		.out_instr(out_instr)
	);

endmodule

//--- tests/tb_warp_frontend.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module tb_warp_frontend;

	localparam int NW = `GPU_NUM_WARPS;
	localparam logic [31:0] PATTERN = 32'hA5A5A5A5;
	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic reset;
	logic cf_valid;
	cf_pkg::cf_op_t cf_op;
	warp_pkg::warp_id_t cf_warp;
	warp_pkg::pc_t cf_pc;
	logic cf_taken;
	warp_pkg::tmask_t cf_mask;
	warp_pkg::tmask_t cf_later_mask;
	cf_pkg::bar_id_t cf_bar_id;
	warp_pkg::wcount_t cf_bar_count;
	logic arvalid;
	logic [31:0] araddr;
	logic [2:0] arprot;
	logic arready;
	logic rvalid;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rready;
	logic out_valid;
	logic out_ready;
	warp_pkg::warp_id_t out_warp;
	warp_pkg::pc_t out_pc;
	warp_pkg::tmask_t out_mask;
	logic [31:0] out_instr;
	logic ebreak;

	integer seed = 75;
	int cycles = 0;
	int errors = 0;
	int checks = 0;

	// Outputs seen on the out port, in order
	warp_pkg::warp_id_t q_warp[$];
	warp_pkg::pc_t q_pc[$];
	warp_pkg::tmask_t q_mask[$];
	logic [31:0] q_instr[$];

	// Memory model state
	logic [31:0] rd_addr;
	logic rd_pending;
	int rd_delay;
	logic r_fire_prev;

	// Reference model of each warp
	warp_pkg::pc_t m_pc [NW];
	warp_pkg::tmask_t m_mask [NW];
	logic [NW-1:0] m_active;
	logic [NW-1:0] m_bar [`GPU_NUM_BARRIERS];
	warp_pkg::ipdom_entry_t m_stack [NW][`GPU_IPDOM_DEPTH];
	int m_sp [NW];

	warp_frontend_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Run stopped after %0d cycles, an expected output never came", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// R beat taken by the DUT at this clock edge
	always @(posedge clk) begin
		r_fire_prev <= rvalid && rready;
	end

	// AXI memory and output sink, everything moves on the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			out_ready = ({$random(seed)} % 4) != 0;
			if (out_valid && out_ready) begin
				q_warp.push_back(out_warp);
				q_pc.push_back(out_pc);
				q_mask.push_back(out_mask);
				q_instr.push_back(out_instr);
			end
			if (r_fire_prev) begin
				rvalid = 1'b0;
			end
			if (rd_pending && !rvalid) begin
				if (rd_delay == 0) begin
					rvalid = 1'b1;
					rdata = rd_addr ^ PATTERN;
					rresp = 2'b00;
					rd_pending = 1'b0;
				end else begin
					rd_delay--;
				end
			end
			arready = ({$random(seed)} % 3) != 0;
			if (arvalid && arready) begin
				check_prot("arprot", arprot, 3'b000);
				rd_addr = araddr;
				rd_pending = 1'b1;
				rd_delay = {$random(seed)} % 4;
			end
		end
	end

	task automatic report(string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic check_warp(string name, warp_pkg::warp_id_t got, warp_pkg::warp_id_t exp);
		checks++;
		if (got !== exp) begin
			report($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_pc(string name, warp_pkg::pc_t got, warp_pkg::pc_t exp);
		checks++;
		if (got !== exp) begin
			report($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_mask(string name, warp_pkg::tmask_t got, warp_pkg::tmask_t exp);
		checks++;
		if (got !== exp) begin
			report($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_instr(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			report($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_prot(string name, logic [2:0] got, logic [2:0] exp);
		checks++;
		if (got !== exp) begin
			report($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			report($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	// Next output from the DUT, compared against the model
	task automatic take_output(output warp_pkg::warp_id_t w);
		warp_pkg::pc_t pc;
		warp_pkg::tmask_t mask;
		logic [31:0] instr;
		logic [NW-1:0] held;
		while (q_warp.size() == 0) begin
			@(negedge clk);
		end
		w = q_warp.pop_front();
		pc = q_pc.pop_front();
		mask = q_mask.pop_front();
		instr = q_instr.pop_front();
		held = m_bar[0] | m_bar[1];
		if (!m_active[w]) begin
			report($sformatf("Warp %0d issued although it is not active", w));
		end
		if (held[w]) begin
			report($sformatf("Warp %0d issued while waiting at a barrier", w));
		end
		check_pc("out_pc", pc, m_pc[w]);
		check_mask("out_mask", mask, m_mask[w]);
		check_instr("out_instr", instr, m_pc[w] ^ PATTERN);
		m_pc[w] = m_pc[w] + 32'd4;
	endtask

	// Drive one event for one cycle and apply it to the model
	task automatic send_event(cf_pkg::cf_op_t op, warp_pkg::warp_id_t w, warp_pkg::pc_t pc,
			logic taken, warp_pkg::tmask_t mask, warp_pkg::tmask_t later,
			cf_pkg::bar_id_t bid, warp_pkg::wcount_t cnt);
		@(negedge clk);
		cf_valid = 1'b1;
		cf_op = op;
		cf_warp = w;
		cf_pc = pc;
		cf_taken = taken;
		cf_mask = mask;
		cf_later_mask = later;
		cf_bar_id = bid;
		cf_bar_count = cnt;
		@(negedge clk);
		cf_valid = 1'b0;
		case (op)
			cf_pkg::CF_JAL: m_pc[w] = pc;
			cf_pkg::CF_BRANCH: if (taken) m_pc[w] = pc;
			cf_pkg::CF_SPLIT: begin
				m_stack[w][m_sp[w]] = '{1'b1, 32'd0, m_mask[w]};
				m_stack[w][m_sp[w] + 1] = '{1'b0, pc, later};
				m_sp[w] += 2;
				m_mask[w] = mask;
			end
			cf_pkg::CF_JOIN: begin
				if (m_sp[w] > 0) begin
					m_sp[w]--;
					m_mask[w] = m_stack[w][m_sp[w]].tmask;
					if (!m_stack[w][m_sp[w]].fallthrough) begin
						m_pc[w] = m_stack[w][m_sp[w]].pc;
					end
				end
			end
			cf_pkg::CF_TMC: begin
				m_mask[w] = mask;
				if (mask == '0) m_active[w] = 1'b0;
			end
			cf_pkg::CF_HALT: m_active[w] = 1'b0;
			cf_pkg::CF_WSPAWN: begin
				for (int i = 1; i < NW; i++) begin
					if (mask[i]) begin
						m_active[i] = 1'b1;
						m_pc[i] = pc;
						m_mask[i] = 1;
					end
				end
			end
			cf_pkg::CF_BAR: begin
				if ($countones(m_bar[bid]) + 1 == cnt) m_bar[bid] = '0;
				else m_bar[bid][w] = 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic advance(warp_pkg::warp_id_t w);
		send_event(cf_pkg::CF_ADVANCE, w, '0, 1'b0, '0, '0, '0, '0);
	endtask

	// Other warps just advance until the target warp comes out
	task automatic event_on(warp_pkg::warp_id_t target, cf_pkg::cf_op_t op, warp_pkg::pc_t pc,
			logic taken, warp_pkg::tmask_t mask, warp_pkg::tmask_t later,
			cf_pkg::bar_id_t bid, warp_pkg::wcount_t cnt);
		warp_pkg::warp_id_t w;
		take_output(w);
		while (w != target) begin
			advance(w);
			take_output(w);
		end
		send_event(op, target, pc, taken, mask, later, bid, cnt);
	endtask

	task automatic finish_test(string name, int err_before);
		if (errors == err_before) $display("%s: ok", name);
		else $display("%s: %0d errors", name, errors - err_before);
	endtask

	task automatic test_single_warp();
		int e0;
		warp_pkg::warp_id_t w;
		e0 = errors;
		// Still the reset state, no clock edge since release
		check_bit("arvalid", arvalid, 1'b0);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("rready", rready, 1'b1);
		check_bit("ebreak", ebreak, 1'b0);
		for (int i = 0; i < 8; i++) begin
			take_output(w);
			check_warp("out_warp", w, 0);
			advance(w);
		end
		finish_test("single warp", e0);
	endtask

	task automatic test_spawn();
		int e0;
		int seen [NW];
		warp_pkg::warp_id_t w;
		e0 = errors;
		for (int i = 0; i < NW; i++) seen[i] = 0;
		event_on(0, cf_pkg::CF_WSPAWN, 32'h8000_1000, 1'b0, 4'b1110, '0, '0, '0);
		for (int i = 0; i < 16; i++) begin
			take_output(w);
			seen[w]++;
			advance(w);
		end
		for (int i = 0; i < NW; i++) begin
			if (seen[i] < 2) report($sformatf("Warp %0d issued only %0d times", i, seen[i]));
		end
		finish_test("warp spawn", e0);
	endtask

	task automatic test_jumps();
		int e0;
		e0 = errors;
		event_on(1, cf_pkg::CF_JAL, 32'h8000_2000, 1'b0, '0, '0, '0, '0);
		event_on(1, cf_pkg::CF_BRANCH, 32'h8000_2400, 1'b1, '0, '0, '0, '0);
		event_on(1, cf_pkg::CF_BRANCH, 32'h8000_2800, 1'b0, '0, '0, '0, '0);
		event_on(1, cf_pkg::CF_ADVANCE, '0, 1'b0, '0, '0, '0, '0);
		finish_test("jal and branch", e0);
	endtask

	task automatic test_divergence();
		int e0;
		e0 = errors;
		event_on(2, cf_pkg::CF_TMC, '0, 1'b0, 4'b1111, '0, '0, '0);
		event_on(2, cf_pkg::CF_SPLIT, 32'h8000_3000, 1'b0, 4'b0011, 4'b1100, '0, '0);
		event_on(2, cf_pkg::CF_JOIN, '0, 1'b0, '0, '0, '0, '0);
		event_on(2, cf_pkg::CF_JOIN, '0, 1'b0, '0, '0, '0, '0);
		event_on(2, cf_pkg::CF_ADVANCE, '0, 1'b0, '0, '0, '0, '0);
		finish_test("split and join", e0);
	endtask

	task automatic test_barrier();
		int e0;
		logic [2:0] resumed;
		warp_pkg::warp_id_t w;
		e0 = errors;
		resumed = '0;
		event_on(0, cf_pkg::CF_BAR, '0, 1'b0, '0, '0, 0, 3);
		event_on(1, cf_pkg::CF_BAR, '0, 1'b0, '0, '0, 0, 3);
		event_on(2, cf_pkg::CF_BAR, '0, 1'b0, '0, '0, 0, 3);
		while (resumed != 3'b111) begin
			take_output(w);
			if (w < 3) resumed[w] = 1'b1;
			advance(w);
		end
		finish_test("barrier", e0);
	endtask

	task automatic test_halt();
		int e0;
		warp_pkg::warp_id_t w;
		e0 = errors;
		while (m_active != '0) begin
			take_output(w);
			check_bit("ebreak", ebreak, 1'b0);
			send_event(cf_pkg::CF_HALT, w, '0, 1'b0, '0, '0, '0, '0);
		end
		repeat (3) @(negedge clk);
		check_bit("ebreak", ebreak, 1'b1);
		if (q_warp.size() != 0) report("Instructions came out after every warp halted");
		finish_test("halt all", e0);
	endtask

	initial begin
		reset = 1'b1;
		cf_valid = 1'b0;
		cf_op = cf_pkg::CF_ADVANCE;
		cf_warp = '0;
		cf_pc = '0;
		cf_taken = 1'b0;
		cf_mask = '0;
		cf_later_mask = '0;
		cf_bar_id = '0;
		cf_bar_count = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		out_ready = 1'b0;
		rd_addr = '0;
		rd_pending = 1'b0;
		rd_delay = 0;
		r_fire_prev = 1'b0;
		for (int i = 0; i < NW; i++) begin
			m_pc[i] = '0;
			m_mask[i] = 1;
			m_sp[i] = 0;
		end
		m_pc[0] = `GPU_START_PC;
		m_active = 1;
		m_bar[0] = '0;
		m_bar[1] = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		test_single_warp();
		test_spawn();
		test_jumps();
		test_divergence();
		test_barrier();
		test_halt();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+source
source/warp_pkg.sv
source/cf_pkg.sv
source/ipdom_stack.sv
source/barrier_table.sv
source/warp_scheduler.sv
source/fetch_stage.sv
source/warp_frontend_top.sv
tests/tb_warp_frontend.sv

//--- run.sh
#!/bin/sh
# Build and run the warp front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
	--top-module tb_warp_frontend -Mdir obj_dir \
	&& ./obj_dir/Vtb_warp_frontend | tee /dev/stderr | grep -q "^No errors$" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
